//--- build.f
rtl/rename_pkg.sv
rtl/front_rat.sv
rtl/free_list.sv
rtl/reorder_buffer.sv
rtl/retire_rat.sv
rtl/rename_core.sv
sim/rename_core_assert.sv
sim/rename_core_tb.sv

//--- rtl/free_list.sv
`timescale 1ns/10ps
`default_nettype none

module free_list (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 flush,
    input  wire logic                 alloc,
    input  wire logic                 retire_valid,
    input  wire rename_pkg::retire_t  retire,
    output rename_pkg::phy_reg_t      new_tag,
    output logic                      has_free
);

    localparam int PW = rename_pkg::FREE_PTR_W;

    // circular queue of free tags
    rename_pkg::phy_reg_t slots [rename_pkg::FREE_DEPTH];

    // spec_head pops at rename, commit_head only at retirement
    logic [PW-1:0] spec_head;
    logic [PW-1:0] commit_head;
    logic [PW-1:0] commit_head_next;
    logic [PW-1:0] tail;

    logic release_tag;

    // a retiring writer frees the tag it replaced
    assign release_tag = retire_valid && retire.rd_valid;

    // the retirement shown during flush still counts as committed
    assign commit_head_next = release_tag ? commit_head + 1'b1 : commit_head;

    assign new_tag = slots[spec_head[PW-2:0]];

    // pointers differ whenever at least one tag is queued
    assign has_free = (spec_head != tail);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            spec_head <= '0;
            commit_head <= '0;
            // queue starts full
            tail <= PW'(rename_pkg::FREE_DEPTH);
            for (int i = 0; i < rename_pkg::FREE_DEPTH; i++) begin
                slots[i] <= rename_pkg::phy_reg_t'(rename_pkg::ARCH_REGS + i);
            end
        end else begin
            commit_head <= commit_head_next;

            if (flush) begin
                // hand the in-flight tags out again in their old order
                spec_head <= commit_head_next;
            end else if (alloc) begin
                spec_head <= spec_head + 1'b1;
            end

            if (release_tag) begin
                slots[tail[PW-2:0]] <= retire.rd_phy_old;
                tail <= tail + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/front_rat.sv
`timescale 1ns/10ps
`default_nettype none

module front_rat (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   flush,
    input  wire logic                   alloc,
    input  wire rename_pkg::rename_req_t req,
    input  wire rename_pkg::phy_reg_t   new_tag,
    input  wire rename_pkg::arch_map_t  committed_map,
    output rename_pkg::phy_reg_t        rs1_phy,
    output rename_pkg::phy_reg_t        rs2_phy,
    output rename_pkg::phy_reg_t        rd_phy_old
);

    // speculative map, ahead of the committed one by all in-flight renames
    rename_pkg::arch_map_t spec_map;

    // source lookups see the map before this cycle's write
    assign rs1_phy = spec_map[req.rs1];
    assign rs2_phy = spec_map[req.rs2];

    // previous mapping of rd, freed once this rename retires
    assign rd_phy_old = spec_map[req.rd];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // identity map out of reset
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                spec_map[i] <= rename_pkg::phy_reg_t'(i);
            end
        end else if (flush) begin
            // throw away wrong-path renames
            spec_map <= committed_map;
        end else if (alloc) begin
            spec_map[req.rd] <= new_tag;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rename_core.sv
`timescale 1ns/10ps
`default_nettype none

module rename_core (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    req_valid,
    input  wire rename_pkg::rename_req_t req,
    input  wire logic                    complete_valid,
    input  wire rename_pkg::complete_t   complete,
    output logic                         rename_ready,
    output rename_pkg::rename_rsp_t      rsp,
    output logic                         retire_valid,
    output rename_pkg::retire_t          retire,
    output logic                         flush
);

    logic                  has_free;
    logic                  alloc;
    rename_pkg::phy_reg_t  new_tag;
    rename_pkg::phy_reg_t  rs1_phy;
    rename_pkg::phy_reg_t  rs2_phy;
    rename_pkg::phy_reg_t  rd_phy_old;
    rename_pkg::arch_map_t committed_map;

    front_rat u_front_rat (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .alloc         (alloc),
        .req           (req),
        .new_tag       (new_tag),
        .committed_map (committed_map),
        .rs1_phy       (rs1_phy),
        .rs2_phy       (rs2_phy),
        .rd_phy_old    (rd_phy_old)
    );

    free_list u_free_list (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .alloc        (alloc),
        .retire_valid (retire_valid),
        .retire       (retire),
        .new_tag      (new_tag),
        .has_free     (has_free)
    );

    // owns acceptance, retirement order and the flush strobe
    reorder_buffer u_rob (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req            (req),
        .has_free       (has_free),
        .new_tag        (new_tag),
        .rs1_phy        (rs1_phy),
        .rs2_phy        (rs2_phy),
        .rd_phy_old     (rd_phy_old),
        .complete_valid (complete_valid),
        .complete       (complete),
        .rename_ready   (rename_ready),
        .alloc          (alloc),
        .rsp            (rsp),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .flush          (flush)
    );

    retire_rat u_retire_rat (
        .clk           (clk),
        .rst           (rst),
        .retire_valid  (retire_valid),
        .retire        (retire),
        .committed_map (committed_map)
    );

endmodule

`default_nettype wire

//--- rtl/rename_pkg.sv
`default_nettype none

package rename_pkg;

    // register file sizes
    localparam int ARCH_REGS = 32;
    localparam int PHY_REGS = 64;

    // tags not held by the committed map start out free
    localparam int FREE_DEPTH = PHY_REGS - ARCH_REGS;
    localparam int ROB_DEPTH = 16;

    localparam int ARCH_W = $clog2(ARCH_REGS);
    localparam int PHY_W = $clog2(PHY_REGS);
    localparam int ROB_ID_W = $clog2(ROB_DEPTH);

    // queue pointers carry one extra wrap bit
    localparam int ROB_PTR_W = ROB_ID_W + 1;
    localparam int FREE_PTR_W = $clog2(FREE_DEPTH) + 1;

    typedef logic [ARCH_W-1:0] arch_reg_t;
    typedef logic [PHY_W-1:0] phy_reg_t;
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // one physical tag per architectural register
    typedef phy_reg_t [ARCH_REGS-1:0] arch_map_t;

    typedef struct packed {
        logic      rd_valid;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
    } rename_req_t;

    typedef struct packed {
        rob_id_t  rob_id;
        phy_reg_t rs1_phy;
        phy_reg_t rs2_phy;
        phy_reg_t rd_phy;
    } rename_rsp_t;

    typedef struct packed {
        rob_id_t rob_id;
        logic    mispredict;
    } complete_t;

    typedef struct packed {
        logic      rd_valid;
        arch_reg_t rd;
        phy_reg_t  rd_phy;
        phy_reg_t  rd_phy_old;
        logic      mispredict;
    } retire_t;

endpackage

`default_nettype wire

//--- rtl/reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    req_valid,
    input  wire rename_pkg::rename_req_t req,
    input  wire logic                    has_free,
    input  wire rename_pkg::phy_reg_t    new_tag,
    input  wire rename_pkg::phy_reg_t    rs1_phy,
    input  wire rename_pkg::phy_reg_t    rs2_phy,
    input  wire rename_pkg::phy_reg_t    rd_phy_old,
    input  wire logic                    complete_valid,
    input  wire rename_pkg::complete_t   complete,
    output logic                         rename_ready,
    output logic                         alloc,
    output rename_pkg::rename_rsp_t      rsp,
    output logic                         retire_valid,
    output rename_pkg::retire_t          retire,
    output logic                         flush
);

    localparam int PW = rename_pkg::ROB_PTR_W;

    typedef struct packed {
        logic                  rd_valid;
        rename_pkg::arch_reg_t rd;
        rename_pkg::phy_reg_t  rd_phy;
        rename_pkg::phy_reg_t  rd_phy_old;
    } rob_entry_t;

    rob_entry_t entries [rename_pkg::ROB_DEPTH];

    // per-slot status written by completion reports
    logic [rename_pkg::ROB_DEPTH-1:0] done;
    logic [rename_pkg::ROB_DEPTH-1:0] mispredict_flag;

    logic [PW-1:0] head;
    logic [PW-1:0] tail;
    rename_pkg::rob_id_t head_id;
    rename_pkg::rob_id_t tail_id;

    logic full;
    logic empty;
    logic accept;
    logic retire_fire;
    rob_entry_t head_entry;
    rob_entry_t new_entry;

    assign head_id = head[PW-2:0];
    assign tail_id = tail[PW-2:0];

    // same slot, opposite wrap bits
    assign full = (head_id == tail_id) && (head[PW-1] != tail[PW-1]);
    assign empty = (head == tail);

    assign rename_ready = !flush && !full && has_free;
    assign accept = req_valid && rename_ready;

    // only writers take a tag from the free list and update the map
    assign alloc = accept && req.rd_valid;

    always_comb begin
        rsp.rob_id = tail_id;
        rsp.rs1_phy = rs1_phy;
        rsp.rs2_phy = rs2_phy;
        rsp.rd_phy = req.rd_valid ? new_tag : '0;
    end

    always_comb begin
        new_entry.rd_valid = req.rd_valid;
        new_entry.rd = req.rd;
        new_entry.rd_phy = rsp.rd_phy;
        new_entry.rd_phy_old = req.rd_valid ? rd_phy_old : '0;
    end

    assign head_entry = entries[head_id];

    // oldest entry leaves once it is done, never while flushing
    assign retire_fire = !flush && !empty && done[head_id];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            done <= '0;
            retire_valid <= 1'b0;
            flush <= 1'b0;
        end else begin
            retire_valid <= retire_fire;
            // shown together with the mispredicting retirement
            flush <= retire_fire && mispredict_flag[head_id];

            if (flush) begin
                // everything still in flight is on the wrong path
                head <= '0;
                tail <= '0;
                done <= '0;
            end else begin
                if (accept) begin
                    tail <= tail + 1'b1;
                    done[tail_id] <= 1'b0;
                end
                if (complete_valid) begin
                    done[complete.rob_id] <= 1'b1;
                end
                if (retire_fire) begin
                    head <= head + 1'b1;
                    done[head_id] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            entries[tail_id] <= new_entry;
        end
        if (complete_valid && !flush) begin
            mispredict_flag[complete.rob_id] <= complete.mispredict;
        end
        if (retire_fire) begin
            retire.rd_valid <= head_entry.rd_valid;
            retire.rd <= head_entry.rd;
            retire.rd_phy <= head_entry.rd_phy;
            retire.rd_phy_old <= head_entry.rd_phy_old;
            retire.mispredict <= mispredict_flag[head_id];
        end
    end

endmodule

`default_nettype wire

//--- rtl/retire_rat.sv
`timescale 1ns/10ps
`default_nettype none

module retire_rat (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                retire_valid,
    input  wire rename_pkg::retire_t retire,
    output rename_pkg::arch_map_t    committed_map
);

    rename_pkg::arch_map_t commit_map;
    logic map_write;

    assign map_write = retire_valid && retire.rd_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                commit_map[i] <= rename_pkg::phy_reg_t'(i);
            end
        end else if (map_write) begin
            commit_map[retire.rd] <= retire.rd_phy;
        end
    end

    // include the retirement shown this cycle, so a flush restores
    // the map with the mispredicting writer already applied
    always_comb begin
        committed_map = commit_map;
        if (map_write) begin
            committed_map[retire.rd] = retire.rd_phy;
        end
    end

endmodule

`default_nettype wire

//--- sim/rename_core_assert.sv
`timescale 1ns/10ps
`default_nettype none

module rename_core_assert (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                flush,
    input wire logic                retire_valid,
    input wire logic                rename_ready,
    input wire rename_pkg::retire_t retire
);

    // number of assertion failures so far
    int fail_count = 0;

    // flush is a one-cycle strobe
    flush_one_cycle: assert property (@(posedge clk) disable iff (rst)
        flush |=> !flush)
        else begin
            $error("flush held for more than one cycle");
            fail_count++;
        end

    // flush only shows up next to the mispredicting record
    flush_with_retire: assert property (@(posedge clk) disable iff (rst)
        flush |-> retire_valid && retire.mispredict)
        else begin
            $error("flush without a mispredicting retirement");
            fail_count++;
        end

    // nothing may leave the ROB while it is emptied
    no_retire_in_flush: assert property (@(posedge clk) disable iff (rst)
        flush |=> !retire_valid)
        else begin
            $error("entry retired during flush");
            fail_count++;
        end

    no_rename_in_flush: assert property (@(posedge clk) disable iff (rst)
        flush |-> !rename_ready)
        else begin
            $error("rename_ready high during flush");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- sim/rename_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rename_core_tb;

    localparam int STEP_LIMIT = 200;

    typedef struct packed {
        rename_pkg::retire_t rec;
        rename_pkg::rob_id_t id;
        logic                done;
    } model_entry_t;

    logic                    clk;
    logic                    rst;
    logic                    req_valid;
    rename_pkg::rename_req_t req;
    logic                    complete_valid;
    rename_pkg::complete_t   complete;
    logic                    rename_ready;
    rename_pkg::rename_rsp_t rsp;
    logic                    retire_valid;
    rename_pkg::retire_t     retire;
    logic                    flush;

    // reference model state
    rename_pkg::phy_reg_t front_map [rename_pkg::ARCH_REGS];
    rename_pkg::phy_reg_t commit_map [rename_pkg::ARCH_REGS];
    rename_pkg::phy_reg_t free_q [$];
    model_entry_t         rob_q [$];
    int                   spec_idx;
    rename_pkg::rob_id_t  next_id;
    integer               seed;
    int                   mis_id;

    rename_core uut (.*);

    bind rename_core rename_core_assert u_assert (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rsp(input rename_pkg::rename_rsp_t exp,
                             input rename_pkg::rename_rsp_t act);
        if (act !== exp) begin
            $display("FAILED time=%0t signal=rsp expected=%h actual=%h", $time, exp, act);
            abort_run();
        end
    endtask

    task automatic check_retire(input rename_pkg::retire_t exp, input rename_pkg::retire_t act);
        if (act !== exp) begin
            $display("FAILED time=%0t signal=retire expected=%h actual=%h", $time, exp, act);
            abort_run();
        end
    endtask

    task automatic expect_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
            abort_run();
        end
    endtask

    function automatic int free_tags();
        return free_q.size() - spec_idx;
    endfunction

    // expected response while the model front end moves on
    function automatic rename_pkg::rename_rsp_t predict_rename(input rename_pkg::rename_req_t r);
        rename_pkg::rename_rsp_t exp;
        model_entry_t e;
        e = '0;
        exp.rob_id = next_id;
        exp.rs1_phy = front_map[r.rs1];
        exp.rs2_phy = front_map[r.rs2];
        exp.rd_phy = '0;
        e.rec.rd_valid = r.rd_valid;
        e.rec.rd = r.rd;
        e.id = next_id;
        if (r.rd_valid) begin
            exp.rd_phy = free_q[spec_idx];
            spec_idx++;
            e.rec.rd_phy = exp.rd_phy;
            e.rec.rd_phy_old = front_map[r.rd];
            front_map[r.rd] = exp.rd_phy;
        end
        next_id++;
        rob_q.push_back(e);
        return exp;
    endfunction

    function automatic rename_pkg::retire_t predict_retire();
        model_entry_t e;
        e = rob_q.pop_front();
        if (e.rec.rd_valid) begin
            commit_map[e.rec.rd] = e.rec.rd_phy;
            // committed head passes this writer's tag and the replaced one joins the tail
            void'(free_q.pop_front());
            free_q.push_back(e.rec.rd_phy_old);
            spec_idx--;
        end
        return e.rec;
    endfunction

    function automatic void restore_on_flush();
        for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
            front_map[i] = commit_map[i];
        end
        spec_idx = 0;
        next_id = '0;
        rob_q.delete();
    endfunction

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        rename_pkg::retire_t exp_ret;
        logic exp_flush;
        logic exp_ready;
        int free_now;
        if (uut.u_assert.fail_count != 0) begin
            $display("a bound assertion failed before %0t", $time);
            abort_run();
        end
        if (!rst) begin
            exp_flush = 1'b0;
            // a tag released by this retirement is free only from the next cycle
            free_now = free_tags();
            if (retire_valid) begin
                if (rob_q.size() == 0) begin
                    $display("retirement reported at %0t with nothing in flight", $time);
                    abort_run();
                end
                if (!rob_q[0].done) begin
                    $display("entry retired at %0t before it was completed", $time);
                    abort_run();
                end
                exp_ret = predict_retire();
                check_retire(exp_ret, retire);
                exp_flush = exp_ret.mispredict;
            end
            expect_level("flush", exp_flush, flush);
            exp_ready = !exp_flush && rob_q.size() < rename_pkg::ROB_DEPTH && free_now > 0;
            expect_level("rename_ready", exp_ready, rename_ready);
            if (req_valid && rename_ready) begin
                check_rsp(predict_rename(req), rsp);
            end
            if (exp_flush) begin
                restore_on_flush();
            end
        end
    end

    // hold one request until rename_ready takes it
    task automatic issue_rename(input logic wr, input int rd, input int rs1, input int rs2);
        int waited;
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req.rd_valid = wr;
        req.rd = rename_pkg::arch_reg_t'(rd);
        req.rs1 = rename_pkg::arch_reg_t'(rs1);
        req.rs2 = rename_pkg::arch_reg_t'(rs2);
        waited = 0;
        @(negedge clk);
        while (!rename_ready) begin
            waited++;
            if (waited > STEP_LIMIT) begin
                $display("timeout at %0t, request never accepted", $time);
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic issue_random(input int n);
        for (int k = 0; k < n; k++) begin
            issue_rename(($random(seed) & 7) != 0, $random(seed) & 31,
                         $random(seed) & 31, $random(seed) & 31);
        end
    endtask

    task automatic idle_request();
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    // complete open entries one per cycle in random order
    task automatic complete_pending(input int mis);
        int open_idx [$];
        int pick;
        int steps;
        model_entry_t e;
        steps = 0;
        do begin
            @(posedge clk);
            #1;
            complete_valid = 1'b0;
            open_idx.delete();
            foreach (rob_q[k]) begin
                if (!rob_q[k].done) begin
                    open_idx.push_back(k);
                end
            end
            if (open_idx.size() > 0 && !flush) begin
                pick = open_idx[$unsigned($random(seed)) % open_idx.size()];
                e = rob_q[pick];
                e.done = 1'b1;
                e.rec.mispredict = (e.id == mis);
                rob_q[pick] = e;
                complete.rob_id = e.id;
                complete.mispredict = e.rec.mispredict;
                complete_valid = 1'b1;
            end
            steps++;
            if (steps > STEP_LIMIT) begin
                $display("timeout at %0t while completing entries", $time);
                abort_run();
            end
        end while (open_idx.size() > 0);
    endtask

    task automatic drain_rob();
        int waited;
        waited = 0;
        while (rob_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > STEP_LIMIT) begin
                $display("timeout at %0t, ROB never drained", $time);
                abort_run();
            end
        end
    endtask

    initial begin
        seed = 99;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        complete_valid = 1'b0;
        complete = '0;
        spec_idx = 0;
        next_id = '0;
        for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
            front_map[i] = rename_pkg::phy_reg_t'(i);
            commit_map[i] = rename_pkg::phy_reg_t'(i);
        end
        for (int i = 0; i < rename_pkg::FREE_DEPTH; i++) begin
            free_q.push_back(rename_pkg::phy_reg_t'(rename_pkg::ARCH_REGS + i));
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // identity map out of reset then dependent sources
        issue_rename(1'b1, 3, 0, 31);
        issue_rename(1'b1, 7, 1, 2);
        issue_rename(1'b0, 0, 5, 6);
        issue_rename(1'b1, 9, 3, 7);
        issue_rename(1'b1, 3, 3, 9);
        idle_request();
        complete_pending(-1);
        drain_rob();

        // shuffled completion order
        issue_random(10);
        idle_request();
        complete_pending(-1);
        drain_rob();

        // fill the ROB so the extra renames wait for retirements
        issue_random(rename_pkg::ROB_DEPTH);
        fork
            issue_random(8);
            begin
                repeat (5) @(posedge clk);
                complete_pending(-1);
            end
        join
        idle_request();
        complete_pending(-1);
        drain_rob();

        // third of six mispredicts and the younger ones get squashed
        mis_id = int'(rename_pkg::rob_id_t'(next_id + 2));
        issue_random(6);
        idle_request();
        complete_pending(mis_id);
        drain_rob();

        // renames after the flush reuse the squashed tags
        issue_random(6);
        idle_request();
        complete_pending(-1);
        drain_rob();

        @(negedge clk);
        if (uut.u_assert.fail_count != 0) begin
            $display("a bound assertion failed near the end of the run");
            abort_run();
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
